/* src/fp32_divsqrt_pkg.sv */
package fp32_divsqrt_pkg;

  // ----------------------------------------
  // word format
  // ----------------------------------------
  localparam int FP_WIDTH  = 32;
  localparam int EXP_WIDTH = 8;
  localparam int MAN_WIDTH = 23;
  localparam int EXP_BIAS  = 127;

  // default quiet nan, positive, only the top mantissa bit set
  localparam logic [FP_WIDTH-1:0] QNAN_CANON = 32'h7FC0_0000;

  // ----------------------------------------
  // operation and rounding
  // ----------------------------------------
  typedef enum logic {
    DIV  = 1'b0,
    SQRT = 1'b1
  } fp_op_e;

  // only RNE is honoured, every other code truncates
  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3,
    RMM = 3'd4
  } round_mode_e;

  // ieee status flags, same bit order as fflags
  typedef struct packed {
    logic NV; // invalid operation
    logic DZ; // divide by zero
    logic OF; // overflow
    logic UF; // underflow
    logic NX; // inexact
  } fp_flags_t;

  // one float word, seen either raw or split into its fields
  typedef union packed {
    logic [FP_WIDTH-1:0] raw;
    struct packed {
      logic                 sign;
      logic [EXP_WIDTH-1:0] exp;
      logic [MAN_WIDTH-1:0] man;
    } fields;
  } fp_word_u;

endpackage

/* src/fp_result_if.sv */
`timescale 1ns/1ps

// request path from one result source into the writeback arbiter
interface fp_result_if
  import fp32_divsqrt_pkg::*;
();

  logic      req;    // source has a result waiting
  logic      grant;  // one-cycle accept from the arbiter
  fp_word_u  result; // held stable while req is up
  fp_flags_t flags;  // status that goes with result

  modport source (
    output req,
    output result,
    output flags,
    input  grant
  );

  modport arbiter (
    input  req,
    input  result,
    input  flags,
    output grant
  );

endinterface

/* src/fp_special_case.sv */
`timescale 1ns/1ps

module fp_special_case
  import fp32_divsqrt_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                start_i,
  input  logic                flush_i,
  input  logic [FP_WIDTH-1:0] op_a_i,
  input  logic [FP_WIDTH-1:0] op_b_i,
  input  fp_op_e              op_i,
  output logic                is_special_o,
  fp_result_if.source         res
);

  fp_word_u  a_w, b_w;
  logic      a_nan, a_snan, a_inf, a_zero;
  logic      b_nan, b_snan, b_inf, b_zero;
  logic      res_sign;
  fp_word_u  spec_word, word_q;
  fp_flags_t spec_flags, flags_q;
  logic      pend_q, req_q;

  // ----------------------------------------
  // operand classes, decoded from the live inputs
  // ----------------------------------------
  assign a_w.raw = op_a_i;
  assign b_w.raw = op_b_i;

  assign a_nan  = (&a_w.fields.exp) & (|a_w.fields.man);
  assign a_snan = a_nan & ~a_w.fields.man[MAN_WIDTH-1]; // quiet bit clear
  assign a_inf  = (&a_w.fields.exp) & ~(|a_w.fields.man);
  assign a_zero = ~(|a_w.fields.exp);                   // subnormals flush here
  assign b_nan  = (&b_w.fields.exp) & (|b_w.fields.man);
  assign b_snan = b_nan & ~b_w.fields.man[MAN_WIDTH-1];
  assign b_inf  = (&b_w.fields.exp) & ~(|b_w.fields.man);
  assign b_zero = ~(|b_w.fields.exp);

  assign res_sign = a_w.fields.sign ^ b_w.fields.sign;

  always_comb begin
    is_special_o = 1'b1;
    spec_word    = '0;
    spec_flags   = '0;
    if (op_i == DIV) begin
      if (a_nan || b_nan) begin
        spec_word.raw = QNAN_CANON;
        spec_flags.NV = a_snan | b_snan; // quiet nans pass silently
      end else if ((a_zero && b_zero) || (a_inf && b_inf)) begin
        spec_word.raw = QNAN_CANON;
        spec_flags.NV = 1'b1;
      end else if (a_inf) begin
        spec_word.fields.sign = res_sign; // inf/x, also inf/0 without DZ
        spec_word.fields.exp  = '1;
      end else if (b_zero) begin
        spec_word.fields.sign = res_sign;
        spec_word.fields.exp  = '1;
        spec_flags.DZ         = 1'b1;
      end else if (a_zero || b_inf) begin
        spec_word.fields.sign = res_sign; // exact signed zero
      end else begin
        is_special_o = 1'b0;
      end
    end else begin
      if (a_nan) begin
        spec_word.raw = QNAN_CANON;
        spec_flags.NV = a_snan;
      end else if (a_zero) begin
        spec_word.fields.sign = a_w.fields.sign; // sqrt(-0) is -0
      end else if (a_w.fields.sign) begin
        spec_word.raw = QNAN_CANON;
        spec_flags.NV = 1'b1;
      end else if (a_inf) begin
        spec_word.fields.exp = '1;
      end else begin
        is_special_o = 1'b0;
      end
    end
  end

  // ----------------------------------------
  // capture, then request one cycle later
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_q <= 1'b0;
      req_q  <= 1'b0;
    end else if (flush_i) begin
      pend_q <= 1'b0;
      req_q  <= 1'b0;
    end else begin
      pend_q <= start_i & is_special_o;
      if (pend_q) begin
        req_q <= 1'b1;
      end else if (res.grant) begin
        req_q <= 1'b0; // granted, bus is free again
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i && is_special_o) begin
      word_q  <= spec_word;
      flags_q <= spec_flags;
    end
  end

  assign res.req    = req_q;
  assign res.result = word_q;
  assign res.flags  = flags_q;

endmodule

/* src/fp_iter_core.sv */
`timescale 1ns/1ps

module fp_iter_core
  import fp32_divsqrt_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                start_i,
  input  logic                is_special_i,
  input  logic                flush_i,
  input  logic [FP_WIDTH-1:0] op_a_i,
  input  logic [FP_WIDTH-1:0] op_b_i,
  input  fp_op_e              op_i,
  input  round_mode_e         rnd_mode_i,
  fp_result_if.source         res
);

  localparam int Q_W     = 26;            // quotient / root bits incl. guard
  localparam int REM_W   = 29;            // room for the sqrt partial remainder
  localparam int RAD_W   = 2 * Q_W;       // sqrt radicand, two bits per step
  localparam int EW      = EXP_WIDTH + 2; // signed exponent with headroom
  localparam int EXP_MAX = (1 << EXP_WIDTH) - 1;

  fp_word_u            a_w, b_w, res_w;
  logic                sqrt_odd;
  logic signed [EW-1:0] exp_start;
  logic                running_q, req_q;
  logic [4:0]          cnt_q;
  fp_op_e              op_q;
  round_mode_e         rnd_q;
  logic                sign_q;
  logic signed [EW-1:0] exp_q;
  logic [MAN_WIDTH:0]  divisor_q;
  logic [REM_W-1:0]    rem_q, cur, trial, nxt;
  logic [Q_W-1:0]      q_q;
  logic [RAD_W-1:0]    rad_q;
  logic                take;
  logic                norm_hi, guard, sticky, round_up;
  logic [MAN_WIDTH:0]  mant;
  logic [MAN_WIDTH+1:0] mant_r;           // one extra bit for the rounding carry
  int                  exp_n, exp_r;
  fp_flags_t           res_flags;

  assign a_w.raw = op_a_i;
  assign b_w.raw = op_b_i;

  // odd unbiased exponent <=> even biased exponent
  assign sqrt_odd = ~a_w.fields.exp[0];

  always_comb begin
    if (op_i == SQRT) begin
      exp_start = EW'((int'(a_w.fields.exp) + EXP_BIAS - int'(sqrt_odd)) / 2);
    end else begin
      exp_start = EW'(int'(a_w.fields.exp) - int'(b_w.fields.exp) + EXP_BIAS);
    end
  end

  // ----------------------------------------
  // restoring step, one bit per cycle
  // ----------------------------------------
  always_comb begin
    if (op_q == SQRT) begin
      cur   = {rem_q[REM_W-3:0], rad_q[RAD_W-1 -: 2]}; // bring down two radicand bits
      trial = {1'b0, q_q, 2'b01};                      // 4*root + 1
    end else begin
      cur   = rem_q;
      trial = REM_W'(divisor_q);
    end
    take = (cur >= trial);
    nxt  = take ? (cur - trial) : cur;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      running_q <= 1'b0;
      req_q     <= 1'b0;
      cnt_q     <= '0;
    end else if (flush_i) begin
      running_q <= 1'b0;
      req_q     <= 1'b0;
    end else begin
      if (start_i && !is_special_i) begin
        running_q <= 1'b1;
        cnt_q     <= 5'(Q_W - 1);
      end else if (running_q) begin
        cnt_q <= cnt_q - 5'd1;
        if (cnt_q == 5'd0) begin
          running_q <= 1'b0;
          req_q     <= 1'b1; // last bit in, result is ready
        end
      end
      if (res.grant) begin
        req_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i && !is_special_i) begin
      op_q      <= op_i;
      rnd_q     <= rnd_mode_i;
      sign_q    <= (op_i == DIV) & (a_w.fields.sign ^ b_w.fields.sign);
      exp_q     <= exp_start;
      divisor_q <= {1'b1, b_w.fields.man};
      q_q       <= '0;
      if (op_i == SQRT) begin
        rem_q <= '0;
        rad_q <= sqrt_odd ? {1'b1, a_w.fields.man, 28'd0} : {2'b01, a_w.fields.man, 27'd0};
      end else begin
        rem_q <= REM_W'({1'b1, a_w.fields.man});
        rad_q <= '0;
      end
    end else if (running_q) begin
      q_q   <= {q_q[Q_W-2:0], take};
      rad_q <= rad_q << 2;
      rem_q <= (op_q == SQRT) ? nxt : {nxt[REM_W-2:0], 1'b0}; // divide shifts the rest
    end
  end

  // ----------------------------------------
  // normalize, round, range check
  // ----------------------------------------
  assign norm_hi  = q_q[Q_W-1];                 // always set for sqrt
  assign mant     = norm_hi ? q_q[Q_W-1:2] : q_q[Q_W-2:1];
  assign guard    = norm_hi ? q_q[1] : q_q[0];
  assign sticky   = (norm_hi & q_q[0]) | (|rem_q);
  assign round_up = (rnd_q == RNE) & guard & (sticky | mant[0]); // ties to even
  assign mant_r   = {1'b0, mant} + (MAN_WIDTH+2)'(round_up);
  assign exp_n    = int'(exp_q) - (norm_hi ? 0 : 1);
  assign exp_r    = exp_n + int'(mant_r[MAN_WIDTH+1]); // carry out bumps exponent

  always_comb begin
    res_w.raw          = '0;
    res_flags          = '0;
    res_w.fields.sign  = sign_q;
    if (exp_r >= EXP_MAX) begin
      res_flags.OF = 1'b1;
      res_flags.NX = 1'b1;
      if (rnd_q == RNE) begin
        res_w.fields.exp = '1;                  // +-inf
      end else begin
        res_w.fields.exp = EXP_WIDTH'(EXP_MAX - 1); // largest finite
        res_w.fields.man = '1;
      end
    end else if (exp_r <= 0) begin
      res_flags.UF = 1'b1; // no subnormals, signed zero
      res_flags.NX = 1'b1;
    end else begin
      res_w.fields.exp = EXP_WIDTH'(exp_r);
      res_w.fields.man = mant_r[MAN_WIDTH-1:0];
      res_flags.NX     = guard | sticky;
    end
  end

  assign res.req    = req_q;
  assign res.result = res_w;
  assign res.flags  = res_flags;

endmodule

/* src/fp_result_arbiter.sv */
`timescale 1ns/1ps

module fp_result_arbiter
  import fp32_divsqrt_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         flush_i,
  output logic         done_o,
  output fp_word_u     result_o,
  output fp_flags_t    flags_o,
  fp_result_if.arbiter spec,
  fp_result_if.arbiter iter
);

  // fixed priority, special path first
  assign spec.grant = spec.req & ~flush_i;
  assign iter.grant = iter.req & ~spec.req & ~flush_i;

  // ----------------------------------------
  // writeback register
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_o <= 1'b0;
    end else begin
      done_o <= spec.grant | iter.grant; // flush already blocks both grants
    end
  end

  always_ff @(posedge clk_i) begin
    if (spec.grant) begin
      result_o <= spec.result;
      flags_o  <= spec.flags;
    end else if (iter.grant) begin
      result_o <= iter.result;
      flags_o  <= iter.flags;
    end
  end

endmodule

/* src/fp_divsqrt_ctrl.sv */
`timescale 1ns/1ps

module fp_divsqrt_ctrl
  import fp32_divsqrt_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                in_valid_i,
  input  logic                flush_i,
  input  logic                out_ready_i,
  input  logic                done_i,
  input  fp_word_u            result_i,
  input  fp_flags_t           flags_i,
  output logic                in_ready_o,
  output logic                start_o,
  output logic [FP_WIDTH-1:0] result_o,
  output fp_flags_t           status_o,
  output logic                out_valid_o,
  output logic                busy_o
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_BUSY = 2'd1; // operation in flight
  localparam logic [1:0] ST_HOLD = 2'd2; // result waiting on downstream

  logic [1:0] state_q, state_d;
  logic       hold_load, data_held;
  fp_word_u   held_result_q;
  fp_flags_t  held_flags_q;

  // ----------------------------------------
  // handshake FSM
  // ----------------------------------------
  always_comb begin
    in_ready_o  = 1'b0;
    out_valid_o = 1'b0;
    busy_o      = 1'b0;
    hold_load   = 1'b0;
    data_held   = 1'b0;
    state_d     = state_q;
    case (state_q)
      ST_IDLE: begin
        in_ready_o = 1'b1;
        if (in_valid_i) state_d = ST_BUSY;
      end
      ST_BUSY: begin
        busy_o = 1'b1;
        if (done_i) begin
          out_valid_o = 1'b1;
          if (out_ready_i) begin
            state_d = ST_IDLE;
            if (in_valid_i) begin // back-to-back, take the next one now
              in_ready_o = 1'b1;
              state_d    = ST_BUSY;
            end
          end else begin
            hold_load = 1'b1; // park the result
            state_d   = ST_HOLD;
          end
        end
      end
      ST_HOLD: begin
        busy_o      = 1'b1;
        data_held   = 1'b1;
        out_valid_o = 1'b1;
        if (out_ready_i) begin
          state_d = ST_IDLE;
          if (in_valid_i) begin
            in_ready_o = 1'b1;
            state_d    = ST_BUSY;
          end
        end
      end
      default: state_d = ST_IDLE;
    endcase
    // flush wins over everything
    if (flush_i) begin
      in_ready_o  = 1'b0;
      out_valid_o = 1'b0;
      busy_o      = 1'b0;
      hold_load   = 1'b0;
      state_d     = ST_IDLE;
    end
  end

  assign start_o = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // hold register, loaded only on a stalled done
  always_ff @(posedge clk_i) begin
    if (hold_load) begin
      held_result_q <= result_i;
      held_flags_q  <= flags_i;
    end
  end

  // ----------------------------------------
  // output select
  // ----------------------------------------
  assign result_o = data_held ? held_result_q.raw : result_i.raw;
  assign status_o = data_held ? held_flags_q : flags_i;

endmodule

/* src/fp32_divsqrt_top.sv */
`timescale 1ns/1ps

module fp32_divsqrt_top
  import fp32_divsqrt_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic [FP_WIDTH-1:0] op_a_i,
  input  logic [FP_WIDTH-1:0] op_b_i,
  input  fp_op_e              op_i,
  input  round_mode_e         rnd_mode_i,
  input  logic                in_valid_i,
  input  logic                flush_i,
  input  logic                out_ready_i,
  output logic                in_ready_o,
  output logic [FP_WIDTH-1:0] result_o,
  output fp_flags_t           status_o,
  output logic                out_valid_o,
  output logic                busy_o
);

  logic      start;      // one-cycle accept pulse
  logic      is_special; // operands resolved without iteration
  logic      done;
  fp_word_u  wb_result;
  fp_flags_t wb_flags;

  fp_result_if spec_if ();
  fp_result_if iter_if ();

  fp_divsqrt_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .flush_i     (flush_i),
    .out_ready_i (out_ready_i),
    .done_i      (done),
    .result_i    (wb_result),
    .flags_i     (wb_flags),
    .in_ready_o  (in_ready_o),
    .start_o     (start),
    .result_o    (result_o),
    .status_o    (status_o),
    .out_valid_o (out_valid_o),
    .busy_o      (busy_o)
  );

  fp_special_case u_special (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .start_i      (start),
    .flush_i      (flush_i),
    .op_a_i       (op_a_i),
    .op_b_i       (op_b_i),
    .op_i         (op_i),
    .is_special_o (is_special),
    .res          (spec_if)
  );

  fp_iter_core u_iter (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .start_i      (start),
    .is_special_i (is_special),
    .flush_i      (flush_i),
    .op_a_i       (op_a_i),
    .op_b_i       (op_b_i),
    .op_i         (op_i),
    .rnd_mode_i   (rnd_mode_i),
    .res          (iter_if)
  );

  fp_result_arbiter u_arb (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .flush_i  (flush_i),
    .done_o   (done),
    .result_o (wb_result),
    .flags_o  (wb_flags),
    .spec     (spec_if),
    .iter     (iter_if)
  );

endmodule

/* tb/fp32_divsqrt_assert.sv */
`timescale 1ns/1ps

module fp32_divsqrt_assert
  import fp32_divsqrt_pkg::*;
(
  input logic                clk_i,
  input logic                rst_n_i,
  input logic                flush_i,
  input logic                out_ready_i,
  input logic                in_ready_i,  // watches in_ready_o of the DUT
  input logic                out_valid_i, // watches out_valid_o
  input logic [FP_WIDTH-1:0] result_i,
  input fp_flags_t           status_i
);

  int unsigned failures = 0; // read by the testbench

  // ----------------------------------------
  // output handshake
  // ----------------------------------------
  valid_until_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
    (out_valid_i && !out_ready_i) |=> out_valid_i)
    else begin
      $error("out_valid_o dropped before out_ready_i");
      failures++;
    end

  // stalled result keeps its word and its flags
  stable_when_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
    (out_valid_i && !out_ready_i) |=> ($stable(result_i) && $stable(status_i)))
    else begin
      $error("result_o or status_o changed while stalled");
      failures++;
    end

  no_accept_in_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_i && !out_ready_i) |-> !in_ready_i) // hold state, nothing new comes in
    else begin
      $error("in_ready_o high while a result waits");
      failures++;
    end

endmodule

bind fp32_divsqrt_top fp32_divsqrt_assert u_assert (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .flush_i     (flush_i),
  .out_ready_i (out_ready_i),
  .in_ready_i  (in_ready_o),
  .out_valid_i (out_valid_o),
  .result_i    (result_o),
  .status_i    (status_o)
);

/* tb/tb_fp32_divsqrt.sv */
`timescale 1ns/1ps

module tb_fp32_divsqrt
  import fp32_divsqrt_pkg::*;
();

  localparam int ACCEPT_LIMIT = 20;  // cycles until in_ready_o
  localparam int RESULT_LIMIT = 100; // iterative path takes about 30
  localparam int SETTLE_LIMIT = 10;  // busy_o after a flush

  // ----------------------------------------
  // operand words
  // ----------------------------------------
  localparam logic [FP_WIDTH-1:0] POS_ZERO = 32'h0000_0000;
  localparam logic [FP_WIDTH-1:0] NEG_ZERO = 32'h8000_0000;
  localparam logic [FP_WIDTH-1:0] HALF     = 32'h3F00_0000;
  localparam logic [FP_WIDTH-1:0] ONE      = 32'h3F80_0000;
  localparam logic [FP_WIDTH-1:0] NEG_ONE  = 32'hBF80_0000;
  localparam logic [FP_WIDTH-1:0] TWO      = 32'h4000_0000;
  localparam logic [FP_WIDTH-1:0] THREE    = 32'h4040_0000;
  localparam logic [FP_WIDTH-1:0] FOUR     = 32'h4080_0000;
  localparam logic [FP_WIDTH-1:0] SIX      = 32'h40C0_0000;
  localparam logic [FP_WIDTH-1:0] MAX_NORM = 32'h7F7F_FFFF;
  localparam logic [FP_WIDTH-1:0] MIN_NORM = 32'h0080_0000;
  localparam logic [FP_WIDTH-1:0] POS_INF  = 32'h7F80_0000;
  localparam fp_flags_t           NO_FLAGS = '0;

  logic                clk_i = 1'b0;
  logic                rst_n_i;
  logic [FP_WIDTH-1:0] op_a_i, op_b_i;
  fp_op_e              op_i;
  round_mode_e         rnd_mode_i;
  logic                in_valid_i, flush_i, out_ready_i;
  logic                in_ready_o, out_valid_o, busy_o;
  logic [FP_WIDTH-1:0] result_o;
  fp_flags_t           status_o;
  integer              seed; // only picks stall lengths

  always #4 clk_i = ~clk_i; // 8 ns period

  fp32_divsqrt_top uut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .op_a_i      (op_a_i),
    .op_b_i      (op_b_i),
    .op_i        (op_i),
    .rnd_mode_i  (rnd_mode_i),
    .in_valid_i  (in_valid_i),
    .flush_i     (flush_i),
    .out_ready_i (out_ready_i),
    .in_ready_o  (in_ready_o),
    .result_o    (result_o),
    .status_o    (status_o),
    .out_valid_o (out_valid_o),
    .busy_o      (busy_o)
  );

  // ----------------------------------------
  // failure reporting and compares
  // ----------------------------------------
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic compare_word(input string name, input logic [FP_WIDTH-1:0] got,
                              input logic [FP_WIDTH-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic compare_flags(input string name, input fp_flags_t got, input fp_flags_t exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s: got 0x%02h, expected 0x%02h", name, got, exp));
    end
  endtask

  task automatic expect_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s: got 0x%1h, expected 0x%1h", name, got, exp));
    end
  endtask

  task automatic expect_latency(input int got, input int exp);
    if (got != exp) begin
      report_failure($sformatf("mismatch latency: got 0x%0h, expected 0x%0h", got, exp));
    end
  endtask

  function automatic fp_flags_t flags_of(input logic nv, input logic dz, input logic of,
                                         input logic uf, input logic nx);
    fp_flags_t f;
    f.NV = nv;
    f.DZ = dz;
    f.OF = of;
    f.UF = uf;
    f.NX = nx;
    return f;
  endfunction

  // ----------------------------------------
  // one operation through the handshake
  // ----------------------------------------
  task automatic wait_accept();
    int waited;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
      if (waited > ACCEPT_LIMIT) report_failure("input was never accepted");
    end while (!in_ready_o); // in_valid_i is already high here
    in_valid_i <= 1'b0;
  endtask

  task automatic drive_op(input logic [FP_WIDTH-1:0] a, input logic [FP_WIDTH-1:0] b,
                          input fp_op_e op, input round_mode_e rnd, input int stall,
                          output logic [FP_WIDTH-1:0] word, output fp_flags_t flags,
                          output int latency);
    op_a_i      <= a;
    op_b_i      <= b;
    op_i        <= op;
    rnd_mode_i  <= rnd;
    in_valid_i  <= 1'b1;
    out_ready_i <= (stall == 0);
    wait_accept();
    latency = 0;
    do begin
      @(posedge clk_i);
      latency++;
      if (latency > RESULT_LIMIT) report_failure("no result appeared on out_valid_o");
      if (!out_valid_o) expect_level("busy_o", busy_o, 1'b1);
    end while (!out_valid_o);
    word  = result_o;
    flags = status_o;
    if (stall > 0) begin
      in_valid_i <= 1'b1; // new work knocks while the result is parked
      repeat (stall) begin // downstream keeps refusing
        @(posedge clk_i);
        expect_level("out_valid_o", out_valid_o, 1'b1);
        expect_level("in_ready_o", in_ready_o, 1'b0);
        expect_level("busy_o", busy_o, 1'b1);
        compare_word("result_o", result_o, word);
        compare_flags("status_o", status_o, flags);
      end
      in_valid_i  <= 1'b0;
      out_ready_i <= 1'b1;
      @(posedge clk_i); // result leaves on this edge
      expect_level("out_valid_o", out_valid_o, 1'b1);
      compare_word("result_o", result_o, word);
      compare_flags("status_o", status_o, flags);
    end
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic exact_results();
    logic [FP_WIDTH-1:0] w;
    fp_flags_t           f;
    int                  lat;
    drive_op(SIX, TWO, DIV, RNE, 0, w, f, lat);
    compare_word("result_o", w, 32'h4040_0000);
    compare_flags("status_o", f, NO_FLAGS);
    drive_op(FOUR, POS_ZERO, SQRT, RNE, 0, w, f, lat);
    compare_word("result_o", w, 32'h4000_0000);
    compare_flags("status_o", f, NO_FLAGS);
    drive_op(TWO, POS_ZERO, SQRT, RNE, 0, w, f, lat); // irrational root
    compare_word("result_o", w, 32'h3FB5_04F3);
    compare_flags("status_o", f, flags_of(1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
  endtask

  task automatic rounding_modes();
    logic [FP_WIDTH-1:0] w;
    fp_flags_t           f;
    int                  lat;
    drive_op(ONE, THREE, DIV, RNE, 0, w, f, lat);
    compare_word("result_o", w, 32'h3EAA_AAAB); // guard set so it rounds up
    compare_flags("status_o", f, flags_of(1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
    drive_op(ONE, THREE, DIV, RTZ, 0, w, f, lat);
    compare_word("result_o", w, 32'h3EAA_AAAA);
    compare_flags("status_o", f, flags_of(1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
  endtask

  task automatic special_operands();
    logic [FP_WIDTH-1:0] w;
    fp_flags_t           f;
    int                  lat;
    drive_op(ONE, POS_ZERO, DIV, RNE, 0, w, f, lat);
    compare_word("result_o", w, POS_INF);
    compare_flags("status_o", f, flags_of(1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
    expect_latency(lat, 3);
    drive_op(POS_ZERO, POS_ZERO, DIV, RNE, 0, w, f, lat);
    compare_word("result_o", w, QNAN_CANON);
    compare_flags("status_o", f, flags_of(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
    expect_latency(lat, 3);
    drive_op(NEG_ONE, POS_ZERO, SQRT, RNE, 0, w, f, lat);
    compare_word("result_o", w, QNAN_CANON);
    compare_flags("status_o", f, flags_of(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
    expect_latency(lat, 3);
    drive_op(NEG_ZERO, POS_ZERO, SQRT, RNE, 0, w, f, lat); // sign kept
    compare_word("result_o", w, NEG_ZERO);
    compare_flags("status_o", f, NO_FLAGS);
    expect_latency(lat, 3);
  endtask

  task automatic range_limits();
    logic [FP_WIDTH-1:0] w;
    fp_flags_t           f;
    int                  lat;
    drive_op(MAX_NORM, HALF, DIV, RNE, 0, w, f, lat);
    compare_word("result_o", w, POS_INF);
    compare_flags("status_o", f, flags_of(1'b0, 1'b0, 1'b1, 1'b0, 1'b1));
    drive_op(MAX_NORM, HALF, DIV, RTZ, 0, w, f, lat); // clamps to largest finite
    compare_word("result_o", w, MAX_NORM);
    compare_flags("status_o", f, flags_of(1'b0, 1'b0, 1'b1, 1'b0, 1'b1));
    drive_op(MIN_NORM, FOUR, DIV, RNE, 0, w, f, lat);
    compare_word("result_o", w, POS_ZERO);
    compare_flags("status_o", f, flags_of(1'b0, 1'b0, 1'b0, 1'b1, 1'b1));
  endtask

  task automatic stalled_output();
    logic [FP_WIDTH-1:0] w;
    fp_flags_t           f;
    int                  lat;
    int                  stall;
    stall = 1 + int'($unsigned($random(seed)) % 8);
    drive_op(ONE, THREE, DIV, RNE, stall, w, f, lat);
    compare_word("result_o", w, 32'h3EAA_AAAB);
    compare_flags("status_o", f, flags_of(1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
    stall = 1 + int'($unsigned($random(seed)) % 8);
    drive_op(NEG_ONE, POS_ZERO, SQRT, RNE, stall, w, f, lat); // special path too
    compare_word("result_o", w, QNAN_CANON);
    compare_flags("status_o", f, flags_of(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
  endtask

  task automatic flush_midway();
    logic [FP_WIDTH-1:0] w;
    fp_flags_t           f;
    int                  lat;
    int                  waited;
    op_a_i      <= ONE;
    op_b_i      <= THREE;
    op_i        <= DIV;
    rnd_mode_i  <= RNE;
    in_valid_i  <= 1'b1;
    out_ready_i <= 1'b1;
    wait_accept();
    repeat (10) begin // core is partway through its loop
      @(posedge clk_i);
      expect_level("out_valid_o", out_valid_o, 1'b0);
    end
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
      if (waited > SETTLE_LIMIT) report_failure("busy_o stayed high after flush_i");
    end while (busy_o);
    repeat (40) begin // flushed result must never show up
      @(posedge clk_i);
      expect_level("out_valid_o", out_valid_o, 1'b0);
    end
    drive_op(SIX, TWO, DIV, RNE, 0, w, f, lat);
    compare_word("result_o", w, 32'h4040_0000);
    compare_flags("status_o", f, NO_FLAGS);
  endtask

  // stop at once when the bound checker fires
  always @(negedge clk_i) begin
    if (uut.u_assert.failures != 0) begin
      report_failure("a protocol assertion on the DUT outputs failed");
    end
  end

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    seed        = 32'hc37b;
    rst_n_i     = 1'b0;
    op_a_i      = '0;
    op_b_i      = '0;
    op_i        = DIV;
    rnd_mode_i  = RNE;
    in_valid_i  = 1'b0;
    flush_i     = 1'b0;
    out_ready_i = 1'b1;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    expect_level("in_ready_o", in_ready_o, 1'b1); // idle after reset
    expect_level("out_valid_o", out_valid_o, 1'b0);
    expect_level("busy_o", busy_o, 1'b0);
    exact_results();
    rounding_modes();
    special_operands();
    range_limits();
    stalled_output();
    flush_midway();
    @(posedge clk_i);
    if (uut.u_assert.failures == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      report_failure("protocol assertions failed during the run");
    end
  end

endmodule

/* fp32_divsqrt.f */
src/fp32_divsqrt_pkg.sv
src/fp_result_if.sv
src/fp_special_case.sv
src/fp_iter_core.sv
src/fp_result_arbiter.sv
src/fp_divsqrt_ctrl.sv
src/fp32_divsqrt_top.sv
tb/fp32_divsqrt_assert.sv
tb/tb_fp32_divsqrt.sv

/* Bender.yml */
package:
  name: fp32_divsqrt

sources:
  - src/fp32_divsqrt_pkg.sv
  - src/fp_result_if.sv
  - src/fp_special_case.sv
  - src/fp_iter_core.sv
  - src/fp_result_arbiter.sv
  - src/fp_divsqrt_ctrl.sv
  - src/fp32_divsqrt_top.sv
  - target: test
    files:
      - tb/fp32_divsqrt_assert.sv
      - tb/tb_fp32_divsqrt.sv
